// ==== hdl/lane_serializer.sv ====
/*
 * Lane serializer
 * takes lane bytes on valid/ready and shifts them out MSB first,
 * or hands the whole byte over in transport mode; idle mode drops bytes
 */
`timescale 1ns/1ps
`include "usb4_rx_params.svh"

module lane_serializer import usb4_rx_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  rx_mode_e    mode,
	input  rx_byte_t    in_data,
	input  logic        in_valid,
	output logic        in_ready,
	lane_bits_if.ser    bits
);

	logic       full;      // shifter holds a byte
	logic [2:0] bit_cnt;   // bits already sent
	rx_byte_t   shift_q;
	logic       os_mode;
	logic       step;
	logic       last;
	logic       take;

	assign os_mode = (mode == MODE_GEN3_TS1) || (mode == MODE_GEN3_TS2) ||
		(mode == MODE_GEN4_TS2) || (mode == MODE_GEN4_TS3) ||
		(mode == MODE_GEN4_TS4);

	////////////////////
	// handshake
	////////////////////
	assign step = full & ~bits.hold;                      // shifter advances
	assign last = os_mode ? (bit_cnt == 3'd7) : 1'b1;     // byte done after this step
	assign in_ready = ~bits.hold & (~full | last);
	assign take = in_valid & in_ready;

	assign bits.bit_valid  = step & os_mode;
	assign bits.bit_data   = shift_q[`RX_BYTE_W-1];        // MSB first
	assign bits.byte_valid = step & (mode == MODE_TRANSPORT);
	assign bits.byte_data  = shift_q;

	////////////////////
	// state
	////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			full    <= 1'b0;
			bit_cnt <= 3'd0;
		end else if (take) begin
			full    <= 1'b1;
			bit_cnt <= 3'd0;   // back to back when the last bit goes out
		end else if (step) begin
			if (last) begin
				full <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			shift_q <= in_data;
		end else if (step) begin
			shift_q <= {shift_q[`RX_BYTE_W-2:0], 1'b0};
		end
	end

endmodule

// ==== hdl/os_detector.sv ====
/*
 * Ordered-set detector for one lane
 * slides serial bits through a 64-bit window and matches the Gen3 set
 * of its lane or the selected Gen4 header; forwards transport bytes.
 * one pending report, the lane is held until it is taken
 */
`timescale 1ns/1ps
`include "usb4_rx_params.svh"

module os_detector import usb4_rx_pkg::*; #(
	parameter int LANE_ID = 0
) (
	input  logic        clk,
	input  logic        rst,
	input  rx_mode_e    mode,
	lane_bits_if.det    bits,
	report_if.src       rpt
);

	// Gen3 sets carry the lane number
	localparam rx_win_t TS1_PAT = (LANE_ID == 0) ? `GEN3_TS1_L0 : `GEN3_TS1_L1;
	localparam rx_win_t TS2_PAT = (LANE_ID == 0) ? `GEN3_TS2_L0 : `GEN3_TS2_L1;

	rx_win_t   win_q;
	rx_win_t   win_nxt;     // window including the newest bit
	rx_mode_e  mode_q;      // last mode, for change detection
	os_head_t  head;
	logic      hit;
	logic      load;
	logic      pend_q;
	rpt_kind_e kind_q;
	rx_mode_e  os_q;
	rx_byte_t  data_q;

	assign win_nxt = {win_q[`RX_WIN_W-2:0], bits.bit_data};
	assign head = win_nxt[`RX_HEAD_W-1:0];

	////////////////////
	// pattern compare
	////////////////////
	always_comb begin
		case (mode)
			MODE_GEN3_TS1: hit = (win_nxt == TS1_PAT);
			MODE_GEN3_TS2: hit = (win_nxt == TS2_PAT);
			MODE_GEN4_TS2: hit = (head == `GEN4_TS2_HEAD);
			MODE_GEN4_TS3: hit = (head == `GEN4_TS3_HEAD);
			MODE_GEN4_TS4: hit = (head == `GEN4_TS4_HEAD);
			default:       hit = 1'b0;   // idle, transport
		endcase
	end

	// the lane is stalled while pending, so no load can collide
	assign load = (bits.bit_valid & hit) | bits.byte_valid;

	////////////////////
	// window
	////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_q  <= '0;
			mode_q <= MODE_IDLE;
		end else begin
			mode_q <= mode;
			if (mode != mode_q) begin
				win_q <= '0;     // new ordered set type, start over
			end else if (bits.bit_valid) begin
				win_q <= win_nxt;
			end
		end
	end

	////////////////////
	// pending report
	////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pend_q <= 1'b0;
		end else if (load) begin
			pend_q <= 1'b1;
		end else if (rpt.ready) begin
			pend_q <= 1'b0;      // taken by the arbiter
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			os_q <= mode;
			if (bits.byte_valid) begin
				kind_q <= KIND_DATA;
				data_q <= bits.byte_data;
			end else begin
				kind_q <= KIND_OS;
				data_q <= '0;
			end
		end
	end

	assign rpt.valid   = pend_q;
	assign rpt.kind    = kind_q;
	assign rpt.os_type = os_q;
	assign rpt.data    = data_q;
	assign bits.hold   = pend_q;   // back-pressure to the serializer

endmodule

// ==== hdl/report_arbiter.sv ====
/*
 * Report arbiter
 * round-robin choice between the two lane report streams into one
 * registered output stage tagged with the lane number
 */
`timescale 1ns/1ps

module report_arbiter import usb4_rx_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	report_if.arb      req0,
	report_if.arb      req1,
	output logic       rpt_valid,
	input  logic       rpt_ready,
	output rpt_kind_e  rpt_kind,
	output lane_id_t   rpt_lane,
	output rx_mode_e   rpt_os,
	output rx_byte_t   rpt_data
);

	lane_id_t last_q;    // lane granted most recently
	lane_id_t pick;      // lane chosen this cycle
	logic     out_free;  // output stage can load
	logic     grant;

	assign out_free = ~rpt_valid | rpt_ready;

	always_comb begin
		if (req0.valid && req1.valid) begin
			pick = ~last_q;                 // alternate on contention
		end else begin
			pick = lane_id_t'(req1.valid);
		end
	end

	assign grant = out_free & (req0.valid | req1.valid);
	assign req0.ready = grant & (pick == 1'b0);
	assign req1.ready = grant & (pick == 1'b1);

	////////////////////
	// output stage
	////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rpt_valid <= 1'b0;
			last_q    <= 1'b1;   // lane 0 wins first
		end else if (grant) begin
			rpt_valid <= 1'b1;
			last_q    <= pick;
		end else if (rpt_ready) begin
			rpt_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (grant) begin
			rpt_lane <= pick;
			rpt_kind <= pick ? req1.kind : req0.kind;
			rpt_os   <= pick ? req1.os_type : req0.os_type;
			rpt_data <= pick ? req1.data : req0.data;
		end
	end

endmodule

// ==== hdl/usb4_rx_if.sv ====
/*
 * USB4 receive path interfaces
 * lane_bits_if links a lane serializer to its detector,
 * report_if carries one lane's reports to the arbiter
 */
`timescale 1ns/1ps

interface lane_bits_if import usb4_rx_pkg::*; ();

	logic     bit_valid;   // one serial bit this cycle
	logic     bit_data;
	logic     byte_valid;  // transport byte this cycle
	rx_byte_t byte_data;
	logic     hold;        // detector busy, stall the lane

	modport ser (
		output bit_valid, bit_data, byte_valid, byte_data,
		input  hold
	);

	modport det (
		input  bit_valid, bit_data, byte_valid, byte_data,
		output hold
	);

endinterface

interface report_if import usb4_rx_pkg::*; ();

	// payload held stable from valid until valid & ready
	logic      valid;
	logic      ready;
	rpt_kind_e kind;
	rx_mode_e  os_type;
	rx_byte_t  data;

	modport src (
		output valid, kind, os_type, data,
		input  ready
	);

	modport arb (
		input  valid, kind, os_type, data,
		output ready
	);

endinterface

// ==== hdl/usb4_rx_params.svh ====
/*
 * USB4 receive path constants
 * lane and window widths, Gen3 ordered-set patterns per lane
 * and the Gen4 ordered-set headers used by the lane detectors
 */
`ifndef USB4_RX_PARAMS_SVH
`define USB4_RX_PARAMS_SVH

////////////////////
// widths
////////////////////
`define RX_BYTE_W 8   // one lane byte
`define RX_WIN_W  64  // sliding detection window
`define RX_HEAD_W 32  // Gen4 ordered-set header

////////////////////
// Gen3 training sets
////////////////////
// second byte carries the lane number
`define GEN3_TS1_L0 64'h01000000040098F2
`define GEN3_TS1_L1 64'h01010000040098F2
`define GEN3_TS2_L0 64'h01000000040064F2
`define GEN3_TS2_L1 64'h01010000040064F2

////////////////////
// Gen4 headers
////////////////////
`define GEN4_TS2_HEAD 32'h7E04B0F0
`define GEN4_TS3_HEAD 32'h7E0690F0
`define GEN4_TS4_HEAD 32'h7E0F0F00

`endif

// ==== hdl/usb4_rx_pkg.sv ====
/*
 * USB4 receive path types
 * lane byte, detection window, Gen4 header and lane number vectors,
 * the detector mode / ordered-set code and the report kind
 */
`include "usb4_rx_params.svh"

package usb4_rx_pkg;

	////////////////////
	// vectors
	////////////////////
	typedef logic [`RX_BYTE_W-1:0] rx_byte_t;  // one byte of a lane
	typedef logic [`RX_WIN_W-1:0]  rx_win_t;   // serial bit window
	typedef logic [`RX_HEAD_W-1:0] os_head_t;  // Gen4 header
	typedef logic [0:0]            lane_id_t;  // lane 0 or 1

	////////////////////
	// enums
	////////////////////
	// selects the detector and tags the ordered set in a report
	typedef enum logic [2:0] {
		MODE_IDLE      = 3'd0,
		MODE_GEN3_TS1  = 3'd1,
		MODE_GEN3_TS2  = 3'd2,
		MODE_GEN4_TS2  = 3'd3,
		MODE_GEN4_TS3  = 3'd4,
		MODE_GEN4_TS4  = 3'd5,
		MODE_TRANSPORT = 3'd6
	} rx_mode_e;

	typedef enum logic {
		KIND_OS   = 1'b0,  // ordered set found
		KIND_DATA = 1'b1   // forwarded transport byte
	} rpt_kind_e;

endpackage

// ==== hdl/usb4_rx_top.sv ====
/*
 * USB4 two-lane receive top
 * per lane a serializer and an ordered-set detector, one shared
 * report stream through the round-robin arbiter
 */
`timescale 1ns/1ps

module usb4_rx_top import usb4_rx_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  rx_mode_e  mode,        // stable while bytes are in flight
	input  rx_byte_t  lane0_data,
	input  logic      lane0_valid,
	output logic      lane0_ready,
	input  rx_byte_t  lane1_data,
	input  logic      lane1_valid,
	output logic      lane1_ready,
	output logic      rpt_valid,
	input  logic      rpt_ready,
	output rpt_kind_e rpt_kind,
	output lane_id_t  rpt_lane,
	output rx_mode_e  rpt_os,
	output rx_byte_t  rpt_data
);

	lane_bits_if bits0 ();
	lane_bits_if bits1 ();
	report_if    rep0 ();
	report_if    rep1 ();

	////////////////////
	// lane 0
	////////////////////
	lane_serializer ser0_i (
		.clk(clk), .rst(rst), .mode(mode),
		.in_data(lane0_data), .in_valid(lane0_valid), .in_ready(lane0_ready),
		.bits(bits0.ser)
	);

	os_detector #(.LANE_ID(0)) det0_i (
		.clk(clk), .rst(rst), .mode(mode), .bits(bits0.det), .rpt(rep0.src)
	);

	////////////////////
	// lane 1
	////////////////////
	lane_serializer ser1_i (
		.clk(clk), .rst(rst), .mode(mode),
		.in_data(lane1_data), .in_valid(lane1_valid), .in_ready(lane1_ready),
		.bits(bits1.ser)
	);

	os_detector #(.LANE_ID(1)) det1_i (
		.clk(clk), .rst(rst), .mode(mode), .bits(bits1.det), .rpt(rep1.src)
	);

	////////////////////
	// shared report bus
	////////////////////
	report_arbiter arb_i (
		.clk(clk), .rst(rst),
		.req0(rep0.arb), .req1(rep1.arb),
		.rpt_valid(rpt_valid), .rpt_ready(rpt_ready),
		.rpt_kind(rpt_kind), .rpt_lane(rpt_lane),
		.rpt_os(rpt_os), .rpt_data(rpt_data)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the USB4 receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f usb4_rx.f --top-module usb4_rx_tb \
	-Mdir obj_dir -o usb4_rx_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/usb4_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: no errors" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== usb4_rx.f ====
+incdir+hdl
hdl/usb4_rx_pkg.sv
hdl/usb4_rx_if.sv
hdl/lane_serializer.sv
hdl/os_detector.sv
hdl/report_arbiter.sv
hdl/usb4_rx_top.sv
verification/usb4_rx_assert.sv
verification/usb4_rx_tb.sv

// ==== verification/usb4_rx_assert.sv ====
/*
 * USB4 receive report checks
 * valid/ready rule on the shared report bus and reset values
 */
`timescale 1ns/1ps

module usb4_rx_assert import usb4_rx_pkg::*; (
	input logic      clk,
	input logic      rst,
	input logic      rpt_valid,
	input logic      rpt_ready,
	input rpt_kind_e rpt_kind,
	input lane_id_t  rpt_lane,
	input rx_mode_e  rpt_os,
	input rx_byte_t  rpt_data,
	input logic      lane0_ready,
	input logic      lane1_ready
);

	// an offered report waits unchanged until taken
	property rpt_hold;
		@(posedge clk) disable iff (!rst)
		rpt_valid && !rpt_ready |=>
			rpt_valid && $stable({rpt_kind, rpt_lane, rpt_os, rpt_data});
	endproperty

	assert property (rpt_hold)
		else $error("report dropped or changed before it was accepted");

	assert property (@(posedge clk) !rst |-> !rpt_valid && lane0_ready && lane1_ready)
		else $error("report bus or lane ready not at reset values");

endmodule

bind usb4_rx_top usb4_rx_assert usb4_rx_assert_i (
	.clk(clk), .rst(rst),
	.rpt_valid(rpt_valid), .rpt_ready(rpt_ready),
	.rpt_kind(rpt_kind), .rpt_lane(rpt_lane), .rpt_os(rpt_os), .rpt_data(rpt_data),
	.lane0_ready(lane0_ready), .lane1_ready(lane1_ready)
);

// ==== verification/usb4_rx_tb.sv ====
/*
 * USB4 receive testbench
 * runs a table of lane byte streams through the two-lane receiver,
 * predicts the reports with a bit-level reference model and checks them
 */
`timescale 1ns/1ps
`include "usb4_rx_params.svh"

module usb4_rx_tb import usb4_rx_pkg::*; ();

	typedef struct {
		string    name;
		rx_mode_e mode;
		rx_win_t  pat0, pat1;   // sent after two zero bytes
		int       len0, len1;   // pattern bytes per lane
		int       nrand;        // random bytes per lane after the pattern
		bit       stall;        // random rpt_ready stalls
		int       n0, n1;       // reports expected per lane
	} test_t;

	typedef struct packed {
		rpt_kind_e kind;
		rx_mode_e  os;
		rx_byte_t  data;
	} exp_t;

	logic      clk = 1'b0;
	logic      rst = 1'b0;
	rx_mode_e  mode = MODE_IDLE;
	rx_byte_t  lane0_data = '0;
	rx_byte_t  lane1_data = '0;
	logic      lane0_valid = 1'b0;
	logic      lane1_valid = 1'b0;
	logic      lane0_ready, lane1_ready;
	logic      rpt_valid;
	logic      rpt_ready = 1'b0;
	rpt_kind_e rpt_kind;
	lane_id_t  rpt_lane;
	rx_mode_e  rpt_os;
	rx_byte_t  rpt_data;

	test_t     tests [9];
	string     cur_name;
	rx_byte_t  bytes0[$], bytes1[$];
	exp_t      exp0[$], exp1[$];
	int        seen [2];
	int        seed = 32'h64a0c608;
	bit        stall_en = 1'b0;
	bit        run_over = 1'b0;
	int        cycle_cnt = 0;
	int        limit;

	usb4_rx_top usb4_rx_top_i (.*);

	always #50 clk = ~clk;

	task automatic stop_on_error();
		run_over = 1'b1;
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first failing check");
	endtask

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_kind(input rpt_kind_e exp, input rpt_kind_e act);
		if (exp !== act) begin
			$display("Error %s: kind expected %s actual %s", cur_name, exp.name(), act.name());
			stop_on_error();
		end
	endtask

	task automatic check_os(input rx_mode_e exp, input rx_mode_e act);
		if (exp !== act) begin
			$display("Error %s: os_type expected %s actual %s", cur_name, exp.name(), act.name());
			stop_on_error();
		end
	endtask

	task automatic check_data(input rx_byte_t exp, input rx_byte_t act);
		if (exp !== act) begin
			$display("Error %s: data expected %h actual %h", cur_name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_count(input int exp, input int act);
		if (exp != act) begin
			$display("Error %s: report count expected %0d actual %0d", cur_name, exp, act);
			stop_on_error();
		end
	endtask

	////////////////////
	// stimulus and model
	////////////////////
	task automatic make_bytes(input bit lane, input rx_win_t pat, input int len, input int nrand);
		rx_byte_t b;
		int       i;
		for (i = 0; i < 2 + len + nrand; i++) begin
			if (i < 2)
				b = '0;                              // zero padding
			else if (i < 2 + len)
				b = pat[8*(len+1-i) +: 8];           // pattern, top byte first
			else
				b = rx_byte_t'($random(seed));
			if (lane)
				bytes1.push_back(b);
			else
				bytes0.push_back(b);
		end
	endtask

	task automatic push_exp(input bit lane, input exp_t e);
		if (lane)
			exp1.push_back(e);
		else
			exp0.push_back(e);
	endtask

	// replays the lane bytes MSB first through a 64-bit window
	task automatic model_lane(input bit lane, input rx_mode_e m);
		rx_win_t  win;
		rx_byte_t b;
		logic     hit;
		int       i;
		int       k;
		win = '0;
		for (i = 0; i < (lane ? bytes1.size() : bytes0.size()); i++) begin
			b = lane ? bytes1[i] : bytes0[i];
			for (k = 7; k >= 0; k--) begin
				win = {win[62:0], b[k]};
				case (m)
					MODE_GEN3_TS1: hit = win == (lane ? `GEN3_TS1_L1 : `GEN3_TS1_L0);
					MODE_GEN3_TS2: hit = win == (lane ? `GEN3_TS2_L1 : `GEN3_TS2_L0);
					MODE_GEN4_TS2: hit = win[31:0] == `GEN4_TS2_HEAD;
					MODE_GEN4_TS3: hit = win[31:0] == `GEN4_TS3_HEAD;
					MODE_GEN4_TS4: hit = win[31:0] == `GEN4_TS4_HEAD;
					default:       hit = 1'b0;
				endcase
				if (hit)
					push_exp(lane, exp_t'{KIND_OS, m, 8'h00});
			end
			if (m == MODE_TRANSPORT)
				push_exp(lane, exp_t'{KIND_DATA, m, b});   // every byte forwarded
		end
	endtask

	task automatic feed_lane(input bit lane);
		int idx;
		idx = 0;
		while (idx < (lane ? bytes1.size() : bytes0.size())) begin
			if (lane) begin
				lane1_valid <= 1'b1;
				lane1_data  <= bytes1[idx];
			end else begin
				lane0_valid <= 1'b1;
				lane0_data  <= bytes0[idx];
			end
			@(posedge clk);
			if (lane ? lane1_ready : lane0_ready)
				idx++;
		end
		if (lane)
			lane1_valid <= 1'b0;
		else
			lane0_valid <= 1'b0;
	endtask

	////////////////////
	// report monitor, ready stalls, timeout
	////////////////////
	always @(posedge clk) begin
		exp_t e;
		if (rst && rpt_valid && rpt_ready) begin
			if ((rpt_lane ? exp1.size() : exp0.size()) == 0) begin
				$display("%s: lane %0d sent a report that was not expected", cur_name, rpt_lane);
				stop_on_error();
			end
			if (rpt_lane)
				e = exp1.pop_front();
			else
				e = exp0.pop_front();
			seen[rpt_lane] += 1;
			check_kind(e.kind, rpt_kind);
			check_os(e.os, rpt_os);
			if (e.kind == KIND_DATA)
				check_data(e.data, rpt_data);
		end
	end

	always @(posedge clk) begin
		rpt_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > limit) begin
			$display("timeout after %0d cycles with reports still missing", cycle_cnt);
			stop_on_error();
		end
	end

	initial begin
		int total;
		int t;
		tests[0] = '{"gen3_ts1", MODE_GEN3_TS1, `GEN3_TS1_L0, `GEN3_TS1_L1, 8, 8, 0, 1'b0, 1, 1};
		tests[1] = '{"gen3_ts2", MODE_GEN3_TS2, `GEN3_TS2_L0, `GEN3_TS2_L1, 8, 8, 0, 1'b1, 1, 1};
		tests[2] = '{"gen3_wrong_lane", MODE_GEN3_TS1, `GEN3_TS1_L0, `GEN3_TS1_L0,
			8, 8, 0, 1'b0, 1, 0};
		tests[3] = '{"gen4_ts2", MODE_GEN4_TS2, rx_win_t'(`GEN4_TS2_HEAD),
			rx_win_t'(`GEN4_TS3_HEAD), 4, 4, 0, 1'b0, 1, 0};
		tests[4] = '{"gen4_ts3", MODE_GEN4_TS3, rx_win_t'(`GEN4_TS3_HEAD),
			rx_win_t'(`GEN4_TS3_HEAD), 4, 4, 0, 1'b0, 1, 1};
		tests[5] = '{"gen4_ts4", MODE_GEN4_TS4, rx_win_t'(`GEN4_TS4_HEAD),
			rx_win_t'(`GEN4_TS2_HEAD), 4, 4, 0, 1'b0, 1, 0};
		tests[6] = '{"transport", MODE_TRANSPORT, '0, '0, 0, 0, 12, 1'b0, 14, 14};
		tests[7] = '{"transport_stall", MODE_TRANSPORT, '0, '0, 0, 0, 24, 1'b1, 26, 26};
		tests[8] = '{"idle_drop", MODE_IDLE, `GEN3_TS1_L0, `GEN3_TS1_L1, 8, 8, 6, 1'b0, 0, 0};
		total = 0;
		foreach (tests[i])
			total += 4 + tests[i].len0 + tests[i].len1 + 2 * tests[i].nrand;
		limit = total * 8 * 4 + 64 * 9;   // plus the gaps between tests

		repeat (4) @(posedge clk);
		rst <= 1'b1;
		for (t = 0; t < 9; t++) begin
			@(negedge clk);
			cur_name = tests[t].name;
			stall_en = tests[t].stall;
			seen = '{0, 0};
			make_bytes(1'b0, tests[t].pat0, tests[t].len0, tests[t].nrand);
			make_bytes(1'b1, tests[t].pat1, tests[t].len1, tests[t].nrand);
			model_lane(1'b0, tests[t].mode);
			model_lane(1'b1, tests[t].mode);
			@(posedge clk);
			mode <= tests[t].mode;              // change from idle clears the windows
			repeat (2) @(posedge clk);
			fork
				feed_lane(1'b0);
				feed_lane(1'b1);
			join
			while (exp0.size() != 0 || exp1.size() != 0)
				@(posedge clk);
			repeat (24) @(posedge clk);         // room for late or extra reports
			check_count(tests[t].n0, seen[0]);
			check_count(tests[t].n1, seen[1]);
			mode <= MODE_IDLE;
			bytes0.delete();
			bytes1.delete();
		end
		run_over = 1'b1;
		$display("Done: no errors");
		$finish;
	end

	// run stopped from outside, e.g. by a failed assertion
	final begin
		if (!run_over)
			$display("Done: errors found");
	end

endmodule
